/* Bender.yml */
package:
  name: enc_ctrl

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/enc_pkg.sv
      - logic/enc_debounce.sv
      - logic/enc_quad_counter.sv
      - logic/enc_period_meas.sv
      - logic/enc_axil_regs.sv
      - logic/enc_ctrl_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/enc_sva.sv
      - verif/enc_tb.sv

/* logic/enc_axil_regs.sv */
`timescale 1ns/1ns
`include "enc_defines.svh"

module enc_axil_regs (
   input  logic                     sysclk,
   input  logic                     arst_n,
   input  enc_pkg::axil_req_t       req,
   output enc_pkg::axil_rsp_t       rsp,
   input  enc_pkg::enc_meas_t       meas    [`ENC_NUM_CHAN],
   output logic [`ENC_CNT_W-1:0]    preload [`ENC_NUM_CHAN],
   output logic [`ENC_NUM_CHAN-1:0] load,
   output enc_pkg::enc_word_t       enc_fb  [`ENC_NUM_CHAN]
);

   // write side
   logic                   awready_q;
   logic                   wready_q;
   logic                   aw_held;     // address latched, waiting for data
   logic                   w_held;      // data latched, waiting for address
   logic [`ENC_ADDR_W-1:0] aw_addr;
   enc_pkg::enc_word_t     w_data;
   logic [3:0]             w_strb;
   enc_pkg::enc_addr_u     aw_dec;
   logic                   wr_commit;
   logic                   wr_pre;      // target is a preload register
   logic                   wr_fb;       // target is FB_SRC
   logic                   bvalid_q;
   enc_pkg::axi_resp_t     bresp_q;

   // read side
   logic                   arready_q;
   logic                   rvalid_q;
   enc_pkg::enc_word_t     rdata_q;
   enc_pkg::enc_addr_u     ar_dec;
   enc_pkg::enc_word_t     rd_word;

   logic [2:0]             fb_src;      // offset code of the feedback field

   // measurement word by channel offset, quad zero extended
   function automatic enc_pkg::enc_word_t meas_field(input enc_pkg::enc_meas_t m,
                                                     input logic [2:0]         sel);
      enc_pkg::enc_word_t w;
      case (sel)
         3'(`ENC_OFF_QUAD): w = 32'(m.quad);
         3'(`ENC_OFF_PERD): w = m.perd;
         3'(`ENC_OFF_QTR):  w = m.qtr;
         3'(`ENC_OFF_RUN):  w = m.run;
         default:           w = '0;     // not a measurement
      endcase
      return w;
   endfunction

   // ----------------------------------------
   // address decode
   // ----------------------------------------
   assign aw_dec = aw_addr;
   assign ar_dec = req.araddr;

   assign wr_pre = !aw_dec.chan_view.region &&
                   (aw_dec.chan_view.offset == `ENC_OFF_PRELOAD) &&
                   (aw_dec.chan_view.chan < `ENC_NUM_CHAN);
   assign wr_fb  = aw_dec.glob_view.region && (aw_dec.glob_view.offset == `ENC_OFF_FB_SRC);
   assign wr_commit = aw_held && w_held && !bvalid_q;

   // readback mux, unmapped reads give zero
   always_comb begin
      rd_word = '0;
      if (!ar_dec.chan_view.region) begin
         if (ar_dec.chan_view.chan < `ENC_NUM_CHAN) begin
            if (ar_dec.chan_view.offset == `ENC_OFF_PRELOAD)
               rd_word = 32'(preload[ar_dec.chan_view.chan]);
            else
               rd_word = meas_field(meas[ar_dec.chan_view.chan], ar_dec.chan_view.offset);
         end
      end else if (ar_dec.glob_view.offset == `ENC_OFF_FB_SRC) begin
         rd_word = 32'(fb_src);
      end else if (ar_dec.glob_view.offset == `ENC_OFF_ID) begin
         rd_word = `ENC_ID_VALUE;
      end
   end

   // ----------------------------------------
   // handshakes and load strobe
   // ----------------------------------------
   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         awready_q <= 1'b0;
         wready_q  <= 1'b0;
         aw_held   <= 1'b0;
         w_held    <= 1'b0;
         bvalid_q  <= 1'b0;
         bresp_q   <= enc_pkg::OKAY;
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
         load      <= '0;
      end else begin
         load <= '0;                               // strobe lasts one cycle
         // write address, ready once per transaction
         if (awready_q && req.awvalid) begin
            awready_q <= 1'b0;
            aw_held   <= 1'b1;
         end else if (req.awvalid && !aw_held && !bvalid_q) begin
            awready_q <= 1'b1;
         end
         // write data, same scheme
         if (wready_q && req.wvalid) begin
            wready_q <= 1'b0;
            w_held   <= 1'b1;
         end else if (req.wvalid && !w_held && !bvalid_q) begin
            wready_q <= 1'b1;
         end
         // both halves held, commit and respond
         if (wr_commit) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            bvalid_q <= 1'b1;
            bresp_q  <= (wr_pre || wr_fb) ? enc_pkg::OKAY : enc_pkg::SLVERR;
            if (wr_pre)
               load[aw_dec.chan_view.chan] <= 1'b1;
         end else if (bvalid_q && req.bready) begin
            bvalid_q <= 1'b0;
         end
         // read, data registered at the address handshake
         if (arready_q && req.arvalid) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b1;
         end else if (rvalid_q && req.rready) begin
            rvalid_q <= 1'b0;
         end else if (req.arvalid && !rvalid_q) begin
            arready_q <= 1'b1;
         end
      end
   end

   // preload and FB_SRC, byte strobes honoured
   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         for (int c = 0; c < `ENC_NUM_CHAN; c++)
            preload[c] <= `ENC_MIDRANGE;
         fb_src <= 3'(`ENC_OFF_QUAD);
      end else if (wr_commit) begin
         if (wr_pre) begin
            for (int i = 0; i < `ENC_CNT_W / 8; i++)
               if (w_strb[i])
                  preload[aw_dec.chan_view.chan][8*i +: 8] <= w_data[8*i +: 8];
         end
         if (wr_fb && w_strb[0])
            fb_src <= w_data[2:0];
      end
   end

   // payload capture
   always_ff @(posedge sysclk) begin
      if (awready_q && req.awvalid)
         aw_addr <= req.awaddr;
      if (wready_q && req.wvalid) begin
         w_data <= req.wdata;
         w_strb <= req.wstrb;
      end
      if (arready_q && req.arvalid)
         rdata_q <= rd_word;                       // held until rready
   end

   // feedback words to the servo loop
   always_comb begin
      for (int c = 0; c < `ENC_NUM_CHAN; c++)
         enc_fb[c] = meas_field(meas[c], fb_src);
   end

   assign rsp.awready = awready_q;
   assign rsp.wready  = wready_q;
   assign rsp.bresp   = bresp_q;
   assign rsp.bvalid  = bvalid_q;
   assign rsp.arready = arready_q;
   assign rsp.rdata   = rdata_q;
   assign rsp.rvalid  = rvalid_q;
   assign rsp.rresp   = enc_pkg::OKAY;             // every read succeeds

endmodule

/* logic/enc_ctrl_top.sv */
`timescale 1ns/1ns
`include "enc_defines.svh"

module enc_ctrl_top (
   input  logic                     sysclk,
   input  logic                     arst_n,
   input  enc_pkg::axil_req_t       req,
   output enc_pkg::axil_rsp_t       rsp,
   input  logic [`ENC_NUM_CHAN-1:0] enc_a,                 // raw a lines
   input  logic [`ENC_NUM_CHAN-1:0] enc_b,                 // raw b lines
   output enc_pkg::enc_word_t       enc_fb [`ENC_NUM_CHAN]
);

   logic [`ENC_NUM_CHAN-1:0] a_filt;
   logic [`ENC_NUM_CHAN-1:0] b_filt;
   logic [`ENC_NUM_CHAN-1:0] dir;
   logic [`ENC_NUM_CHAN-1:0] load;                         // preload strobes
   logic [`ENC_CNT_W-1:0]    preload [`ENC_NUM_CHAN];
   enc_pkg::enc_meas_t       meas    [`ENC_NUM_CHAN];

   // ----------------------------------------
   // per channel datapath
   // ----------------------------------------
   for (genvar c = 0; c < `ENC_NUM_CHAN; c++) begin : g_chan
      logic [`ENC_CNT_W:0] quad;
      enc_pkg::enc_word_t  qtr;
      enc_pkg::enc_word_t  perd;
      enc_pkg::enc_word_t  run;

      enc_debounce u_deb_a (
         .sysclk (sysclk),
         .arst_n (arst_n),
         .raw    (enc_a[c]),
         .filt   (a_filt[c])
      );

      enc_debounce u_deb_b (
         .sysclk (sysclk),
         .arst_n (arst_n),
         .raw    (enc_b[c]),
         .filt   (b_filt[c])
      );

      // position
      enc_quad_counter u_quad (
         .sysclk  (sysclk),
         .arst_n  (arst_n),
         .a       (a_filt[c]),
         .b       (b_filt[c]),
         .load    (load[c]),
         .preload (preload[c]),
         .quad    (quad),
         .dir     (dir[c])
      );

      // velocity as edge periods
      enc_period_meas u_perd (
         .sysclk (sysclk),
         .arst_n (arst_n),
         .a      (a_filt[c]),
         .b      (b_filt[c]),
         .dir    (dir[c]),
         .qtr    (qtr),
         .perd   (perd),
         .run    (run)
      );

      assign meas[c] = '{quad: quad, perd: perd, qtr: qtr, run: run};
   end

   enc_axil_regs u_regs (
      .sysclk  (sysclk),
      .arst_n  (arst_n),
      .req     (req),
      .rsp     (rsp),
      .meas    (meas),
      .preload (preload),
      .load    (load),
      .enc_fb  (enc_fb)
   );

endmodule

/* logic/enc_debounce.sv */
`timescale 1ns/1ns
`include "enc_defines.svh"

module enc_debounce (
   input  logic sysclk,
   input  logic arst_n,
   input  logic raw,    // encoder line straight from the pin
   output logic filt    // synchronized and filtered level
);

   localparam int CNT_W = $clog2(`ENC_DEB_CYCLES + 1);

   logic             sync1;         // metastability flop
   logic             sync2;
   logic [CNT_W-1:0] stable_cnt;    // samples of sync2 != filt in a row

   // two flop synchronizer
   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         sync1 <= 1'b0;
         sync2 <= 1'b0;
      end else begin
         sync1 <= raw;
         sync2 <= sync1;
      end
   end

   // fixed delay filter, so edge spacing comes out unchanged
   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         stable_cnt <= '0;
         filt       <= 1'b0;
      end else if (sync2 == filt) begin
         stable_cnt <= '0;                               // glitch gone, start over
      end else if (stable_cnt == CNT_W'(`ENC_DEB_CYCLES - 1)) begin
         stable_cnt <= '0;
         filt       <= sync2;                            // level held long enough
      end else begin
         stable_cnt <= stable_cnt + 1'b1;
      end
   end

endmodule

/* logic/enc_defines.svh */
`ifndef ENC_DEFINES_SVH
`define ENC_DEFINES_SVH

// ----------------------------------------
// channel and datapath sizing
// ----------------------------------------
`define ENC_NUM_CHAN    4              // encoder channels
`define ENC_CNT_W       24             // position counter width
`define ENC_DEB_CYCLES  4              // stable samples before filt follows raw
`define ENC_MIDRANGE    24'h800000     // counter and preload after reset
`define ENC_ADDR_W      8              // axi byte address width

// channel region, word offsets
`define ENC_OFF_PRELOAD 0
`define ENC_OFF_QUAD    1              // {ovf, count}
`define ENC_OFF_PERD    2              // sum of last four quarter periods
`define ENC_OFF_QTR     3              // latest quarter period
`define ENC_OFF_RUN     4              // cycles since last edge

// global region, word offsets
`define ENC_OFF_FB_SRC  0              // feedback source select
`define ENC_OFF_ID      1
`define ENC_ID_VALUE    32'h454E_4304  // "ENC" tag, low byte is channel count

`endif

/* logic/enc_period_meas.sv */
`timescale 1ns/1ns

module enc_period_meas (
   input  logic               sysclk,
   input  logic               arst_n,
   input  logic               a,       // filtered a line
   input  logic               b,       // filtered b line
   input  logic               dir,     // from the quadrature counter
   output enc_pkg::enc_word_t qtr,
   output enc_pkg::enc_word_t perd,
   output enc_pkg::enc_word_t run
);

   localparam logic [30:0] MAG_MAX = '1;   // 31 bit magnitude ceiling

   logic [1:0]  ab_prev;
   logic        ab_edge;     // any filtered transition
   logic [30:0] qtr_new;
   logic [30:0] qtr_mag;     // latest quarter period
   logic [30:0] qtr_d1;      // one before
   logic [30:0] qtr_d2;      // two before
   logic [32:0] perd_sum;    // room for four magnitudes
   logic [30:0] perd_new;
   logic [30:0] perd_mag;

   assign ab_edge = ({a, b} != ab_prev);

   // ----------------------------------------
   // next values, both saturating
   // ----------------------------------------
   assign qtr_new  = (run >= {1'b0, MAG_MAX}) ? MAG_MAX : run[30:0] + 1'b1;
   assign perd_sum = 33'(qtr_new) + 33'(qtr_mag) + 33'(qtr_d1) + 33'(qtr_d2);
   assign perd_new = (|perd_sum[32:31]) ? MAG_MAX : perd_sum[30:0];

   // sign bit follows the direction of the latest step
   assign qtr  = {dir, qtr_mag};
   assign perd = {dir, perd_mag};

   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         ab_prev  <= 2'b00;
         run      <= '0;
         qtr_mag  <= '0;
         qtr_d1   <= '0;
         qtr_d2   <= '0;
         perd_mag <= '0;
      end else begin
         ab_prev <= {a, b};
         if (ab_edge) begin
            run      <= '0;          // restart the timer
            qtr_mag  <= qtr_new;
            qtr_d1   <= qtr_mag;
            qtr_d2   <= qtr_d1;
            perd_mag <= perd_new;
         end else if (!(&run)) begin
            run <= run + 1'b1;       // holds at all ones
         end
      end
   end

endmodule

/* logic/enc_pkg.sv */
`include "enc_defines.svh"

package enc_pkg;

   typedef logic [31:0] enc_word_t;   // one bus data word

   // results of one encoder channel
   typedef struct packed {
      logic [`ENC_CNT_W:0] quad;   // overflow flag above the count
      enc_word_t           perd;   // four edge period, dir in msb
      enc_word_t           qtr;    // latest edge to edge period, dir in msb
      enc_word_t           run;    // running timer
   } enc_meas_t;

   // ----------------------------------------
   // byte address decode
   // ----------------------------------------
   typedef struct packed {
      logic       region;      // 0 for channel registers
      logic [1:0] chan;
      logic [2:0] offset;      // word offset within the channel
      logic [1:0] byte_lane;   // ignored, word access only
   } enc_chan_addr_t;

   typedef struct packed {
      logic       region;      // 1 for global registers
      logic [4:0] offset;
      logic [1:0] byte_lane;
   } enc_glob_addr_t;

   // same address word, read per region
   typedef union packed {
      enc_chan_addr_t chan_view;
      enc_glob_addr_t glob_view;
   } enc_addr_u;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axi_resp_t;

   // ----------------------------------------
   // axi4-lite, master and slave halves
   // ----------------------------------------
   typedef struct packed {
      logic [`ENC_ADDR_W-1:0] awaddr;
      logic                   awvalid;
      enc_word_t              wdata;
      logic [3:0]             wstrb;
      logic                   wvalid;
      logic                   bready;
      logic [`ENC_ADDR_W-1:0] araddr;
      logic                   arvalid;
      logic                   rready;
   } axil_req_t;

   typedef struct packed {
      logic      awready;
      logic      wready;
      axi_resp_t bresp;
      logic      bvalid;
      logic      arready;
      enc_word_t rdata;
      logic      rvalid;
      axi_resp_t rresp;
   } axil_rsp_t;

endpackage

/* logic/enc_quad_counter.sv */
`timescale 1ns/1ns
`include "enc_defines.svh"

module enc_quad_counter (
   input  logic                  sysclk,
   input  logic                  arst_n,
   input  logic                  a,         // filtered a line
   input  logic                  b,         // filtered b line
   input  logic                  load,      // one cycle preload strobe
   input  logic [`ENC_CNT_W-1:0] preload,
   output logic [`ENC_CNT_W:0]   quad,      // {ovf, count}
   output logic                  dir        // 1 when a leads b
);

   logic [1:0]            ab_prev;
   logic [1:0]            ab_cur;
   logic                  step;    // exactly one line moved
   logic                  up;
   logic [`ENC_CNT_W-1:0] count;
   logic                  ovf;     // sticky wrap flag

   assign ab_cur = {a, b};
   assign step   = (ab_cur[1] ^ ab_prev[1]) ^ (ab_cur[0] ^ ab_prev[0]);  // double step fails
   // forward gray order 00 -> 10 -> 11 -> 01
   assign up     = ab_cur[1] ^ ab_prev[0];
   assign quad   = {ovf, count};

   always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
         ab_prev <= 2'b00;
         count   <= `ENC_MIDRANGE;
         ovf     <= 1'b0;
         dir     <= 1'b0;
      end else begin
         ab_prev <= ab_cur;
         if (step)
            dir <= up;
         if (load) begin
            count <= preload;    // bus preload wins over a step
            ovf   <= 1'b0;
         end else if (step) begin
            if (up) begin
               count <= count + 1'b1;
               if (&count)
                  ovf <= 1'b1;   // wrapped past all ones
            end else begin
               count <= count - 1'b1;
               if (count == '0)
                  ovf <= 1'b1;   // wrapped below zero
            end
         end
      end
   end

endmodule

/* project.f */
+incdir+logic
logic/enc_pkg.sv
logic/enc_debounce.sv
logic/enc_quad_counter.sv
logic/enc_period_meas.sv
logic/enc_axil_regs.sv
logic/enc_ctrl_top.sv
verif/enc_sva.sv
verif/enc_tb.sv

/* verif/enc_sva.sv */
`timescale 1ns/1ns
`include "enc_defines.svh"

module enc_sva (
   input logic                     sysclk,
   input logic                     arst_n,
   input enc_pkg::axil_req_t       req,
   input enc_pkg::axil_rsp_t       rsp,
   input logic [`ENC_NUM_CHAN-1:0] load
);

   // read data parked until the master takes it
   property rd_hold;
      @(posedge sysclk) disable iff (!arst_n)
         rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata);
   endproperty

   // write response parked the same way
   property wr_hold;
      @(posedge sysclk) disable iff (!arst_n)
         rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp);
   endproperty

   // preload strobe is a single cycle per channel
   property load_single;
      @(posedge sysclk) disable iff (!arst_n)
         (load & $past(load)) == '0;
   endproperty

   a_rd_hold:     assert property (rd_hold)     else $error("read response changed before rready");
   a_wr_hold:     assert property (wr_hold)     else $error("write response changed before bready");
   a_load_single: assert property (load_single) else $error("load strobe held for two cycles");

endmodule

bind enc_axil_regs enc_sva sva_i (
   .sysclk (sysclk),
   .arst_n (arst_n),
   .req    (req),
   .rsp    (rsp),
   .load   (load)
);

/* verif/enc_tb.sv */
`timescale 1ns/1ns
`include "enc_defines.svh"

module enc_tb;

   localparam int N       = `ENC_NUM_CHAN;
   localparam int LAG     = 2 + `ENC_DEB_CYCLES + 1;   // raw step to visible measurement
   localparam int TIMEOUT = 50;                        // cycles per handshake wait

   typedef struct packed {
      logic [`ENC_ADDR_W-1:0] addr;
      enc_pkg::enc_word_t     got;
      enc_pkg::enc_word_t     exp;
      enc_pkg::axi_resp_t     resp;
      logic                   at_least;     // exp is only a lower bound (run timer)
   } rd_item_t;

   logic                  sysclk;
   logic                  arst_n;
   enc_pkg::axil_req_t    req;
   enc_pkg::axil_rsp_t    rsp;
   logic [N-1:0]          enc_a;
   logic [N-1:0]          enc_b;
   enc_pkg::enc_word_t    enc_fb [N];

   integer                seed = 32'h1f9;
   int                    cyc  = 0;              // rising edges seen
   rd_item_t              rd_q [$];              // finished reads, waiting for the checker

   // ----------------------------------------
   // reference state
   // ----------------------------------------
   logic [`ENC_CNT_W-1:0] m_count   [N];
   logic                  m_ovf     [N];
   logic                  m_dir     [N];         // 1 when a leads b
   logic [`ENC_CNT_W-1:0] m_preload [N];
   logic [2:0]            m_fb_src;
   int                    last_step [N];         // cyc of last raw step, -1 before any
   enc_pkg::enc_word_t    spc       [N][4];      // edge spacings, newest at [3]

   enc_ctrl_top enc_ctrl_top_i (
      .sysclk (sysclk),
      .arst_n (arst_n),
      .req    (req),
      .rsp    (rsp),
      .enc_a  (enc_a),
      .enc_b  (enc_b),
      .enc_fb (enc_fb)
   );

   initial begin
      sysclk = 1'b0;
      forever #5 sysclk = ~sysclk;
   end

   always @(posedge sysclk) cyc <= cyc + 1;

   function automatic logic [7:0] chan_addr(input int c, input int off);
      return {1'b0, 2'(c), 3'(off), 2'b00};
   endfunction

   function automatic logic [7:0] glob_addr(input int off);
      return {1'b1, 5'(off), 2'b00};
   endfunction

   function automatic int rand_hold();
      return `ENC_DEB_CYCLES + 2 + ($unsigned($random(seed)) % 8);
   endfunction

   // one measurement field, run only as its lower bound
   function automatic enc_pkg::enc_word_t field_model(input int c, input int off);
      enc_pkg::enc_word_t sum;
      int                 age;
      sum = '0;
      for (int i = 0; i < 4; i++)
         sum = sum + spc[c][i];
      age = cyc - last_step[c] - LAG;
      case (off)
         `ENC_OFF_QUAD: return {7'd0, m_ovf[c], m_count[c]};
         `ENC_OFF_PERD: return {m_dir[c], sum[30:0]};
         `ENC_OFF_QTR:  return {m_dir[c], spc[c][3][30:0]};
         `ENC_OFF_RUN:  return (last_step[c] < 0 || age < 0) ? '0 : age;
         default:       return '0;
      endcase
   endfunction

   function automatic enc_pkg::enc_word_t enc_model(input logic [7:0] addr);
      int c;
      int off;
      c   = addr[6:5];
      off = addr[4:2];
      if (!addr[7])
         return (off == `ENC_OFF_PRELOAD) ? {8'd0, m_preload[c]} : field_model(c, off);
      if (addr[6:2] == `ENC_OFF_FB_SRC)
         return {29'd0, m_fb_src};
      if (addr[6:2] == `ENC_OFF_ID)
         return `ENC_ID_VALUE;
      return '0;                                 // unmapped
   endfunction

   // applies a write to the model, gives the expected bresp
   function automatic enc_pkg::axi_resp_t write_model(input logic [7:0] addr,
                                                      input enc_pkg::enc_word_t data);
      if (!addr[7] && addr[4:2] == `ENC_OFF_PRELOAD) begin
         m_preload[addr[6:5]] = data[`ENC_CNT_W-1:0];
         m_count[addr[6:5]]   = data[`ENC_CNT_W-1:0];   // load strobe follows
         m_ovf[addr[6:5]]     = 1'b0;
         return enc_pkg::OKAY;
      end
      if (addr[7] && addr[6:2] == `ENC_OFF_FB_SRC) begin
         m_fb_src = data[2:0];
         return enc_pkg::OKAY;
      end
      return enc_pkg::SLVERR;                    // read only or unmapped
   endfunction

   task automatic stop_fail(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input enc_pkg::enc_word_t got,
                             input enc_pkg::enc_word_t exp);
      if (got !== exp)
         stop_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
   endtask

   task automatic check_at_least(input string name, input enc_pkg::enc_word_t got,
                                 input enc_pkg::enc_word_t lo);
      if ($isunknown(got) || got < lo)
         stop_fail($sformatf("Fail %s: got %h, expected at least %h", name, got, lo));
   endtask

   task automatic check_resp(input string name, input enc_pkg::axi_resp_t got,
                             input enc_pkg::axi_resp_t exp);
      if (got !== exp)
         stop_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
   endtask

   task automatic tick();
      @(posedge sysclk);
      #1;                                        // drive and sample off the edge
   endtask

   // ----------------------------------------
   // axi4-lite master
   // ----------------------------------------
   task automatic axi_write(input logic [7:0] addr, input enc_pkg::enc_word_t data,
                            input int bwait);
      enc_pkg::axi_resp_t first;
      logic               aw_hs;
      logic               w_hs;
      int                 n;
      req.awaddr  = addr;
      req.awvalid = 1'b1;
      req.wdata   = data;
      req.wstrb   = 4'hf;
      req.wvalid  = 1'b1;
      n = 0;
      while (req.awvalid || req.wvalid) begin
         aw_hs = req.awvalid && rsp.awready;     // handshake on the coming edge
         w_hs  = req.wvalid && rsp.wready;
         tick();
         if (aw_hs)
            req.awvalid = 1'b0;
         if (w_hs)
            req.wvalid = 1'b0;
         n++;
         if (n > TIMEOUT)
            stop_fail("write address or data was never accepted");
      end
      n = 0;
      while (!rsp.bvalid) begin
         tick();
         n++;
         if (n > TIMEOUT)
            stop_fail("no write response arrived");
      end
      first = rsp.bresp;
      repeat (bwait) begin                       // bready held low
         tick();
         if (!rsp.bvalid)
            stop_fail("bvalid dropped before bready");
         check_resp("bresp", rsp.bresp, first);
      end
      req.bready = 1'b1;
      tick();
      req.bready = 1'b0;
      check_resp("bresp", first, write_model(addr, data));
   endtask

   task automatic axi_read(input logic [7:0] addr, input int rwait);
      rd_item_t it;
      logic     hs;
      int       n;
      it.addr     = addr;
      it.exp      = enc_model(addr);             // expected at issue time
      it.at_least = !addr[7] && addr[4:2] == `ENC_OFF_RUN;
      req.araddr  = addr;
      req.arvalid = 1'b1;
      n = 0;
      while (req.arvalid) begin
         hs = rsp.arready;
         tick();
         if (hs)
            req.arvalid = 1'b0;
         n++;
         if (n > TIMEOUT)
            stop_fail("read address was never accepted");
      end
      n = 0;
      while (!rsp.rvalid) begin
         tick();
         n++;
         if (n > TIMEOUT)
            stop_fail("no read data arrived");
      end
      it.got  = rsp.rdata;
      it.resp = rsp.rresp;
      repeat (rwait) begin                       // rready held low
         tick();
         if (!rsp.rvalid)
            stop_fail("rvalid dropped before rready");
         check_word("rdata", rsp.rdata, it.got);
         check_resp("rresp", rsp.rresp, it.resp);
      end
      req.rready = 1'b1;
      tick();
      req.rready = 1'b0;
      rd_q.push_back(it);
   endtask

   // one gray step on channel c, forward means a leads b
   task automatic enc_step(input int c, input logic fwd, input int hold);
      logic [1:0] nxt;
      nxt = fwd ? {~enc_b[c], enc_a[c]} : {enc_b[c], ~enc_a[c]};   // 00 10 11 01 forward
      enc_a[c] = nxt[1];
      enc_b[c] = nxt[0];
      if (fwd) begin
         if (&m_count[c])
            m_ovf[c] = 1'b1;
         m_count[c] = m_count[c] + 1'b1;
      end else begin
         if (m_count[c] == '0)
            m_ovf[c] = 1'b1;
         m_count[c] = m_count[c] - 1'b1;
      end
      m_dir[c] = fwd;
      if (last_step[c] >= 0) begin
         for (int i = 0; i < 3; i++)
            spc[c][i] = spc[c][i+1];
         spc[c][3] = cyc - last_step[c];
      end
      last_step[c] = cyc;
      repeat (hold) tick();
   endtask

   // compares every finished read against the model
   always @(posedge sysclk) begin : check_reads
      rd_item_t it;
      while (rd_q.size() > 0) begin
         it = rd_q.pop_front();
         check_resp($sformatf("rresp @%h", it.addr), it.resp, enc_pkg::OKAY);
         if (it.at_least)
            check_at_least($sformatf("rdata @%h", it.addr), it.got, it.exp);
         else
            check_word($sformatf("rdata @%h", it.addr), it.got, it.exp);
      end
   end

   initial begin
      enc_pkg::enc_word_t exp;
      arst_n   = 1'b0;
      req      = '0;
      enc_a    = '0;
      enc_b    = '0;
      m_fb_src = 3'(`ENC_OFF_QUAD);
      for (int c = 0; c < N; c++) begin
         m_count[c]   = `ENC_MIDRANGE;
         m_preload[c] = `ENC_MIDRANGE;
         m_ovf[c]     = 1'b0;
         m_dir[c]     = 1'b0;
         last_step[c] = -1;
         for (int i = 0; i < 4; i++)
            spc[c][i] = '0;
      end
      repeat (2) @(posedge sysclk);
      #1 arst_n = 1'b1;
      tick();
      if (rsp.bvalid || rsp.rvalid || rsp.awready || rsp.wready || rsp.arready)
         stop_fail("a handshake output is high after reset");

      // reset values
      for (int c = 0; c < N; c++) begin
         axi_read(chan_addr(c, `ENC_OFF_PRELOAD), 0);
         axi_read(chan_addr(c, `ENC_OFF_QUAD), 0);
      end
      axi_read(glob_addr(`ENC_OFF_FB_SRC), 0);
      axi_read(glob_addr(`ENC_OFF_ID), 0);
      axi_read(chan_addr(0, 6), 0);              // unmapped, reads zero
      axi_read(glob_addr(2), 0);

      // preload, then writes that must be refused
      for (int c = 0; c < N; c++) begin
         axi_write(chan_addr(c, `ENC_OFF_PRELOAD), $random(seed), 0);
         axi_read(chan_addr(c, `ENC_OFF_PRELOAD), 0);
         axi_read(chan_addr(c, `ENC_OFF_QUAD), 0);
         axi_write(chan_addr(c, `ENC_OFF_QUAD), 32'h0012_3456, 0);     // SLVERR
         axi_read(chan_addr(c, `ENC_OFF_QUAD), 0);
      end
      axi_write(glob_addr(`ENC_OFF_ID), 32'h0, 0);
      axi_read(glob_addr(`ENC_OFF_ID), 0);

      // random walks, then a wrap through all ones
      for (int c = 0; c < N; c++) begin
         repeat (20) enc_step(c, 1'($random(seed)), rand_hold());
         repeat (LAG + 2) tick();
         axi_read(chan_addr(c, `ENC_OFF_QUAD), 0);
      end
      axi_write(chan_addr(0, `ENC_OFF_PRELOAD), 32'h00ff_fffd, 0);
      repeat (5) enc_step(0, 1'b1, rand_hold());
      repeat (LAG + 2) tick();
      axi_read(chan_addr(0, `ENC_OFF_QUAD), 0);

      // known spacings for the period meter
      for (int c = 0; c < N; c++) begin
         for (int k = 0; k < 5; k++)
            enc_step(c, c[0], 6 + 3 * k + c);
         repeat (LAG + 2) tick();
         axi_read(chan_addr(c, `ENC_OFF_QTR), 0);
         axi_read(chan_addr(c, `ENC_OFF_PERD), 0);
         axi_read(chan_addr(c, `ENC_OFF_RUN), 0);
      end

      // ----------------------------------------
      // feedback mux, every code
      // ----------------------------------------
      for (int s = 0; s < 8; s++) begin
         axi_write(glob_addr(`ENC_OFF_FB_SRC), s, 0);
         axi_read(glob_addr(`ENC_OFF_FB_SRC), 0);
         for (int c = 0; c < N; c++) begin
            exp = field_model(c, s);
            if (s == `ENC_OFF_RUN)
               check_at_least($sformatf("enc_fb[%0d]", c), enc_fb[c], exp);
            else
               check_word($sformatf("enc_fb[%0d]", c), enc_fb[c], exp);
         end
      end
      axi_write(glob_addr(`ENC_OFF_FB_SRC), `ENC_OFF_QUAD, 0);

      // back-pressure on both response channels
      for (int i = 0; i < 8; i++) begin
         axi_write(chan_addr(i % N, `ENC_OFF_PRELOAD), $random(seed), rand_hold());
         axi_read(chan_addr(i % N, `ENC_OFF_QUAD), rand_hold());
         axi_write(chan_addr(i % N, `ENC_OFF_RUN), 32'h1, rand_hold());   // refused
      end

      repeat (3) tick();
      if (rd_q.size() != 0)
         stop_fail("read results were left unchecked");
      else
         $display("*** PASSED ***");
      $finish;
   end

endmodule
